// File: design/byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if;
	logic valid;
	logic ready;
	logic [7:0] data;
	logic last; // final byte of a frame

	modport source (
		output valid, data, last,
		input ready
	);

	modport sink (
		input valid, data, last,
		output ready
	);
endinterface

// File: design/frame_sender.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module frame_sender import motor_bus_pkg::*; #(
	parameter int NUM_MOTORS = 4
) (
	input logic clk,
	input logic reset,
	input logic [7:0] id [NUM_MOTORS],
	input logic signed [31:0] setpoint [NUM_MOTORS],
	byte_stream_if.source out,
	input logic frame_sent,
	input logic rsp_done,
	input logic need_command,
	output logic [`MB_IDX_W(NUM_MOTORS)-1:0] poll_motor,
	output logic rsp_timeout
);
	localparam int MOTOR_W = `MB_IDX_W(NUM_MOTORS);
	localparam int TMR_W = $clog2(`MB_RSP_TIMEOUT + 1);
	localparam int GAP_W = $clog2(`MB_POLL_GAP + 1);

	sender_state_e state;
	frame_kind_e kind;
	logic [3:0] idx;
	logic [3:0] frame_len;
	logic [15:0] crc;
	logic [7:0] id_r;
	logic signed [31:0] setp_r;
	logic [31:0] header;
	logic [7:0] cur_byte;
	logic [TMR_W-1:0] timer;
	logic [GAP_W-1:0] gap_cnt;
	logic frame_open; // queued or still on the line
	logic xfer;

	assign xfer = out.valid && out.ready;
	assign header = (kind == fk_command) ? `MB_CMD_HEADER : `MB_REQ_HEADER;
	assign frame_len = (kind == fk_command) ? 4'(`MB_CMD_LEN) : 4'(`MB_REQ_LEN);

	always_comb begin
		if (idx < 4'(`MB_HDR_LEN))
			cur_byte = header[8 * (3 - int'(idx)) +: 8]; // header big-endian
		else if (idx == 4'(`MB_HDR_LEN))
			cur_byte = id_r;
		else if (idx == frame_len - 4'd2)
			cur_byte = crc[15:8];
		else if (idx == frame_len - 4'd1)
			cur_byte = crc[7:0];
		else
			cur_byte = setp_r[8 * (int'(idx) - 5) +: 8]; // setpoint lsb first
	end

	assign out.valid = (state == s_send_request) || (state == s_send_command);
	assign out.data = cur_byte;
	assign out.last = (idx == frame_len - 4'd1);

	always_ff @(posedge clk) begin
		if (state == s_idle)
			id_r <= id[poll_motor];
		if (state == s_wait_response && rsp_done && need_command)
			setp_r <= setpoint[poll_motor];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= s_gap;
			kind <= fk_request;
			idx <= '0;
			crc <= 16'hffff;
			timer <= '0;
			gap_cnt <= GAP_W'(`MB_POLL_GAP - 1);
			frame_open <= 1'b0;
			poll_motor <= MOTOR_W'(NUM_MOTORS - 1); // wraps to motor 0 on the first poll
			rsp_timeout <= 1'b0;
		end else begin
			rsp_timeout <= 1'b0;
			if (frame_sent)
				timer <= TMR_W'(`MB_RSP_TIMEOUT - 1);
			if (xfer && out.last)
				frame_open <= 1'b1;
			else if (frame_sent)
				frame_open <= 1'b0;
			if (xfer) begin
				idx <= idx + 4'd1;
				if (idx >= 4'(`MB_HDR_LEN) && idx < frame_len - 4'd2)
					crc <= crc16_next(crc, cur_byte);
			end
			case (state)
				s_idle: begin
					kind <= fk_request;
					idx <= '0;
					crc <= 16'hffff;
					gap_cnt <= GAP_W'(`MB_POLL_GAP - 1);
					state <= s_send_request;
				end
				s_send_request: begin
					if (xfer && out.last)
						state <= s_wait_response;
				end
				s_wait_response: begin
					if (rsp_done) begin
						if (need_command) begin
							kind <= fk_command;
							idx <= '0;
							crc <= 16'hffff;
							state <= s_send_command;
						end else begin
							state <= s_gap;
						end
					end else if (!frame_open && timer == '0) begin
						rsp_timeout <= 1'b1;
						state <= s_gap;
					end else if (!frame_open) begin
						timer <= timer - 1'b1;
					end
				end
				s_send_command: begin
					if (xfer && out.last)
						state <= s_gap;
				end
				s_gap: begin
					if (gap_cnt != '0) begin
						gap_cnt <= gap_cnt - 1'b1;
					end else if (!frame_open) begin // line must be free again
						poll_motor <= (poll_motor == MOTOR_W'(NUM_MOTORS - 1)) ? '0 :
							poll_motor + 1'b1;
						state <= s_idle;
					end
				end
			endcase
		end
	end

	a_hold_until_ready: assert property (@(posedge clk) disable iff (reset)
		out.valid && !out.ready |=> out.valid && $stable(out.data) && $stable(out.last));

endmodule

// File: design/motor_bus_consts.svh
`ifndef MOTOR_BUS_CONSTS_SVH
`define MOTOR_BUS_CONSTS_SVH

`define MB_BIT_CLKS 8 // clocks per uart bit

`define MB_REQ_HEADER 32'h1CE1CEBB
`define MB_RSP_HEADER 32'hDABAD000
`define MB_CMD_HEADER 32'hCAFEBABE

// frame lengths in bytes including header and crc
`define MB_REQ_LEN 7
`define MB_RSP_LEN 27
`define MB_CMD_LEN 11
`define MB_HDR_LEN 4

`define MB_RSP_TIMEOUT 6000 // counted from the end of the request
`define MB_POLL_GAP 64
`define MB_FIFO_DEPTH 8

`define MB_IDX_W(n) (((n) > 1) ? $clog2(n) : 1)

`endif

// File: design/motor_bus_master.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module motor_bus_master import motor_bus_pkg::*; #(
	parameter int NUM_MOTORS = 4
) (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic tx,
	output logic tx_enable,
	input logic [7:0] id [NUM_MOTORS],
	input logic signed [31:0] setpoint [NUM_MOTORS],
	output logic signed [31:0] position0 [NUM_MOTORS],
	output logic signed [31:0] position1 [NUM_MOTORS],
	output logic signed [31:0] displacement [NUM_MOTORS],
	output logic signed [31:0] pwm [NUM_MOTORS],
	output mb_error_e error_code [NUM_MOTORS]
);
	localparam int MOTOR_W = `MB_IDX_W(NUM_MOTORS);

	byte_stream_if frame_bytes ();
	byte_stream_if line_bytes ();

	logic frame_sent;
	logic rx_valid;
	logic [7:0] rx_data;
	logic [MOTOR_W-1:0] poll_motor;
	logic rsp_timeout;
	logic rsp_done;
	logic need_command;

	frame_sender #(.NUM_MOTORS(NUM_MOTORS)) u_frame_sender (
		.clk(clk), .reset(reset),
		.id(id), .setpoint(setpoint),
		.out(frame_bytes),
		.frame_sent(frame_sent),
		.rsp_done(rsp_done), .need_command(need_command),
		.poll_motor(poll_motor), .rsp_timeout(rsp_timeout)
	);

	tx_byte_fifo u_tx_byte_fifo (
		.clk(clk), .reset(reset),
		.in(frame_bytes), .out(line_bytes)
	);

	uart_tx u_uart_tx (
		.clk(clk), .reset(reset),
		.in(line_bytes),
		.tx(tx), .tx_enable(tx_enable), .frame_sent(frame_sent)
	);

	uart_rx u_uart_rx (
		.clk(clk), .reset(reset),
		.rx(rx), .rx_valid(rx_valid), .rx_data(rx_data)
	);

	status_receiver #(.NUM_MOTORS(NUM_MOTORS)) u_status_receiver (
		.clk(clk), .reset(reset),
		.rx_valid(rx_valid), .rx_data(rx_data),
		.poll_motor(poll_motor), .rsp_timeout(rsp_timeout),
		.id(id), .setpoint(setpoint),
		.rsp_done(rsp_done), .need_command(need_command),
		.position0(position0), .position1(position1),
		.displacement(displacement), .pwm(pwm),
		.error_code(error_code)
	);

endmodule

// File: design/motor_bus_pkg.sv
package motor_bus_pkg;

	typedef enum logic [7:0] {
		mb_ok = 8'd0,
		mb_pending = 8'd1,
		mb_crc_error = 8'd2,
		mb_id_mismatch = 8'd3,
		mb_timeout = 8'd4
	} mb_error_e;

	typedef enum logic [2:0] {
		s_idle,
		s_send_request,
		s_wait_response,
		s_send_command,
		s_gap
	} sender_state_e;

	typedef enum logic [1:0] {
		r_hunt,
		r_collect,
		r_check
	} receiver_state_e;

	typedef enum logic {
		fk_request,
		fk_command
	} frame_kind_e;

	// last field on the wire sits at the top
	typedef struct packed {
		logic signed [31:0] pwm;
		logic signed [31:0] displacement;
		logic signed [31:0] position1;
		logic signed [31:0] position0;
		logic signed [31:0] setpoint;
	} mb_status_t;

	// crc-16 poly 0x1021, msb first
	function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc ^ {data, 8'h00};
		for (int i = 0; i < 8; i++) begin
			if (c[15])
				c = {c[14:0], 1'b0} ^ 16'h1021;
			else
				c = {c[14:0], 1'b0};
		end
		return c;
	endfunction

endpackage

// File: design/status_receiver.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module status_receiver import motor_bus_pkg::*; #(
	parameter int NUM_MOTORS = 4
) (
	input logic clk,
	input logic reset,
	input logic rx_valid,
	input logic [7:0] rx_data,
	input logic [`MB_IDX_W(NUM_MOTORS)-1:0] poll_motor,
	input logic rsp_timeout,
	input logic [7:0] id [NUM_MOTORS],
	input logic signed [31:0] setpoint [NUM_MOTORS],
	output logic rsp_done,
	output logic need_command,
	output logic signed [31:0] position0 [NUM_MOTORS],
	output logic signed [31:0] position1 [NUM_MOTORS],
	output logic signed [31:0] displacement [NUM_MOTORS],
	output logic signed [31:0] pwm [NUM_MOTORS],
	output mb_error_e error_code [NUM_MOTORS]
);
	receiver_state_e state;
	logic [31:0] hdr_sr;
	logic [31:0] hdr_next;
	logic [4:0] cnt; // index of the next byte in the frame
	logic [15:0] crc;
	logic [15:0] crc_rx;
	logic [7:0] rsp_id;
	mb_status_t rec;
	logic chk_phase;
	logic crc_ok;
	logic id_ok;
	logic setp_diff;

	assign hdr_next = {hdr_sr[23:0], rx_data};

	always_ff @(posedge clk) begin
		if (state == r_collect && rx_valid) begin
			if (cnt == 5'(`MB_HDR_LEN))
				rsp_id <= rx_data;
			else if (cnt < 5'(`MB_RSP_LEN - 2))
				rec <= {rx_data, rec[$bits(rec)-1:8]};
			else
				crc_rx <= {crc_rx[7:0], rx_data};
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= r_hunt;
			hdr_sr <= '0;
			cnt <= '0;
			crc <= 16'hffff;
			chk_phase <= 1'b0;
			crc_ok <= 1'b0;
			id_ok <= 1'b0;
			setp_diff <= 1'b0;
			rsp_done <= 1'b0;
			need_command <= 1'b0;
			for (int m = 0; m < NUM_MOTORS; m++) begin
				error_code[m] <= mb_pending;
				position0[m] <= '0;
				position1[m] <= '0;
				displacement[m] <= '0;
				pwm[m] <= '0;
			end
		end else begin
			rsp_done <= 1'b0;
			need_command <= 1'b0;
			case (state)
				r_hunt: begin
					if (rx_valid) begin
						hdr_sr <= hdr_next;
						if (hdr_next == `MB_RSP_HEADER) begin
							hdr_sr <= '0;
							cnt <= 5'(`MB_HDR_LEN);
							crc <= 16'hffff;
							state <= r_collect;
						end
					end
				end
				r_collect: begin
					if (rsp_timeout) begin
						state <= r_hunt;
					end else if (rx_valid) begin
						cnt <= cnt + 5'd1;
						if (cnt < 5'(`MB_RSP_LEN - 2))
							crc <= crc16_next(crc, rx_data);
						if (cnt == 5'(`MB_RSP_LEN - 1)) begin
							chk_phase <= 1'b0;
							state <= r_check;
						end
					end
				end
				r_check: begin
					if (rsp_timeout) begin
						state <= r_hunt;
					end else if (!chk_phase) begin
						crc_ok <= (crc == crc_rx);
						id_ok <= (rsp_id == id[poll_motor]);
						setp_diff <= (rec.setpoint != setpoint[poll_motor]);
						chk_phase <= 1'b1;
					end else begin
						rsp_done <= 1'b1;
						state <= r_hunt;
						if (!crc_ok) begin
							error_code[poll_motor] <= mb_crc_error;
						end else if (!id_ok) begin
							error_code[poll_motor] <= mb_id_mismatch;
						end else begin
							position0[poll_motor] <= rec.position0;
							position1[poll_motor] <= rec.position1;
							displacement[poll_motor] <= rec.displacement;
							pwm[poll_motor] <= rec.pwm;
							error_code[poll_motor] <= mb_ok;
							need_command <= setp_diff;
						end
					end
				end
			endcase
			if (rsp_timeout)
				error_code[poll_motor] <= mb_timeout;
		end
	end

	// a poll ends either with a response or with a timeout, never both
	a_done_xor_timeout: assert property (@(posedge clk) disable iff (reset)
		!(rsp_done && rsp_timeout));

endmodule

// File: design/tx_byte_fifo.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module tx_byte_fifo (
	input logic clk,
	input logic reset,
	byte_stream_if.sink in,
	byte_stream_if.source out
);
	localparam int DEPTH = `MB_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	logic [8:0] mem [DEPTH]; // {last, data}
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic wr_en;
	logic rd_en;

	assign wr_en = in.valid && in.ready;
	assign rd_en = out.valid && out.ready;
	assign in.ready = (count != (AW + 1)'(DEPTH));
	assign out.valid = (count != '0);
	assign out.data = mem[rd_ptr][7:0];
	assign out.last = mem[rd_ptr][8];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= {in.last, in.data};
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	// pointers must agree with the count
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (wr_ptr != rd_ptr) || (count == '0));
	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		rd_en |-> (wr_ptr != rd_ptr) || (count == (AW + 1)'(DEPTH)));

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module uart_rx (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic rx_valid,
	output logic [7:0] rx_data
);
	localparam int CNT_W = $clog2(`MB_BIT_CLKS);

	logic [1:0] rx_sync;
	logic rx_s;
	logic busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0] bit_num; // 0 start, 1..8 data, 9 stop
	logic [7:0] shreg;

	assign rx_s = rx_sync[1];
	assign rx_data = shreg;

	always_ff @(posedge clk) begin
		if (busy && clk_cnt == '0 && bit_num >= 4'd1 && bit_num <= 4'd8)
			shreg <= {rx_s, shreg[7:1]}; // lsb arrives first
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_sync <= 2'b11;
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_num <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			if (!busy) begin
				if (!rx_s) begin
					busy <= 1'b1;
					clk_cnt <= CNT_W'(`MB_BIT_CLKS / 2 - 1); // aim at mid-bit
					bit_num <= '0;
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= CNT_W'(`MB_BIT_CLKS - 1);
				bit_num <= bit_num + 4'd1;
				if (bit_num == 4'd0 && rx_s) begin
					busy <= 1'b0; // glitch, no real start bit
				end else if (bit_num == 4'd9) begin
					busy <= 1'b0;
					rx_valid <= rx_s; // low stop bit drops the byte
				end
			end
		end
	end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module uart_tx (
	input logic clk,
	input logic reset,
	byte_stream_if.sink in,
	output logic tx,
	output logic tx_enable,
	output logic frame_sent
);
	localparam int CNT_W = $clog2(`MB_BIT_CLKS);

	logic busy;
	logic last_r;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0] bit_num;
	logic [9:0] shreg; // stop, data, start

	assign in.ready = !busy;
	assign tx = shreg[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			last_r <= 1'b0;
			clk_cnt <= '0;
			bit_num <= '0;
			shreg <= '1; // idle line high
			tx_enable <= 1'b0;
			frame_sent <= 1'b0;
		end else begin
			frame_sent <= 1'b0;
			if (!busy) begin
				if (in.valid) begin
					shreg <= {1'b1, in.data, 1'b0};
					last_r <= in.last;
					busy <= 1'b1;
					clk_cnt <= '0;
					bit_num <= '0;
					tx_enable <= 1'b1;
				end
			end else if (clk_cnt != CNT_W'(`MB_BIT_CLKS - 1)) begin
				clk_cnt <= clk_cnt + 1'b1;
			end else begin
				clk_cnt <= '0;
				shreg <= {1'b1, shreg[9:1]};
				bit_num <= bit_num + 4'd1;
				if (bit_num == 4'd9) begin // end of stop bit
					busy <= 1'b0;
					if (last_r) begin
						tx_enable <= 1'b0;
						frame_sent <= 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: motor_bus_master.f
+incdir+design
design/motor_bus_pkg.sv
design/byte_stream_if.sv
design/frame_sender.sv
design/tx_byte_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/status_receiver.sv
design/motor_bus_master.sv
testbench/tb_motor_model.sv
testbench/tb_motor_bus_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the motor bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f motor_bus_master.f \
	--top-module tb_motor_bus_master \
	-o sim_motor_bus_master
status=$?
if [ $status -ne 0 ]; then
	echo "compile step failed with status $status"
	exit $status
fi

./obj_dir/sim_motor_bus_master
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished"
exit 0

// File: testbench/tb_motor_bus_master.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module tb_motor_bus_master import motor_bus_pkg::*; ();
	localparam int POLLS = 24;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic tx_enable;
	logic [7:0] id [4];
	logic signed [31:0] setpoint [4];
	logic signed [31:0] position0 [4];
	logic signed [31:0] position1 [4];
	logic signed [31:0] displacement [4];
	logic signed [31:0] pwm [4];
	mb_error_e error_code [4];

	logic [1:0] mode;
	logic signed [31:0] rd [4]; // pos0, pos1, disp, pwm for the next reply
	int req_count;
	int cmd_count;
	logic [7:0] req_id;
	logic req_crc_ok;
	logic cmd_crc_ok;
	logic signed [31:0] cmd_setp [4];

	// expected state of the bus
	logic signed [31:0] exp_rd [4][4];
	logic signed [31:0] exp_rep [4]; // setpoint the motor reports
	int exp_cmds;

	motor_bus_master #(.NUM_MOTORS(4)) u_motor_bus_master (
		.clk(clk), .reset(reset), .rx(rx), .tx(tx), .tx_enable(tx_enable),
		.id(id), .setpoint(setpoint),
		.position0(position0), .position1(position1),
		.displacement(displacement), .pwm(pwm), .error_code(error_code)
	);

	tb_motor_model u_model (
		.clk(clk), .line_in(tx), .line_out(rx), .id(id), .mode(mode),
		.rd_pos0(rd[0]), .rd_pos1(rd[1]), .rd_disp(rd[2]), .rd_pwm(rd[3]),
		.req_count(req_count), .req_id(req_id), .req_crc_ok(req_crc_ok),
		.cmd_count(cmd_count), .cmd_crc_ok(cmd_crc_ok), .cmd_setp(cmd_setp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_reading(input string name, input logic signed [31:0] exp,
			input logic signed [31:0] act);
		if (exp !== act)
			report_failure($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_error(input string name, input mb_error_e exp, input mb_error_e act);
		if (exp !== act)
			report_failure($sformatf("mismatch %s expected %s actual %s", name,
				exp.name(), act.name()));
	endtask

	task automatic check_setpoint(input string name, input logic signed [31:0] exp,
			input logic signed [31:0] act);
		if (exp !== act)
			report_failure($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_id(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act)
			report_failure($sformatf("mismatch %s expected %02h actual %02h", name, exp, act));
	endtask

	// half-duplex line driver
	always @(negedge clk) begin
		if (!reset) begin
			if (!tx && !tx_enable)
				report_failure("tx carries a low bit while tx_enable is off");
			if (!rx && tx_enable)
				report_failure("tx_enable is on while a motor is answering");
		end
	end

	task automatic wait_request(input int target);
		int n;
		n = 0;
		while (req_count < target) begin
			@(posedge clk);
			n++;
			if (n > 20000)
				report_failure($sformatf("no request frame %0d from the master", target));
		end
	endtask

	// results of one poll, judged once the next request shows up
	task automatic judge_poll(input int k, input logic [1:0] pm,
			input logic signed [31:0] snap, input logic signed [31:0] prd [4]);
		int m;
		mb_error_e exp_err;
		m = k % 4;
		case (pm)
			2'd0: exp_err = mb_ok;
			2'd1: exp_err = mb_crc_error;
			2'd2: exp_err = mb_id_mismatch;
			default: exp_err = mb_timeout;
		endcase
		if (pm == 2'd0) begin
			for (int f = 0; f < 4; f++)
				exp_rd[m][f] = prd[f];
			if (snap != exp_rep[m]) begin
				exp_cmds++;
				exp_rep[m] = snap;
			end
		end
		check_error($sformatf("poll %0d error_code", k), exp_err, error_code[m]);
		check_reading($sformatf("poll %0d position0", k), exp_rd[m][0], position0[m]);
		check_reading($sformatf("poll %0d position1", k), exp_rd[m][1], position1[m]);
		check_reading($sformatf("poll %0d displacement", k), exp_rd[m][2], displacement[m]);
		check_reading($sformatf("poll %0d pwm", k), exp_rd[m][3], pwm[m]);
		check_setpoint($sformatf("poll %0d commanded setpoint", k), exp_rep[m], cmd_setp[m]);
		if (cmd_count != exp_cmds)
			report_failure($sformatf("poll %0d saw %0d command frames, expected %0d", k,
				cmd_count, exp_cmds));
		if (cmd_count > 0 && !cmd_crc_ok)
			report_failure("command frame arrived with a bad crc");
	endtask

	initial begin
		logic [1:0] prev_mode;
		logic signed [31:0] prev_rd [4];
		logic signed [31:0] snap;
		void'($urandom(62851));
		reset = 1'b1;
		mode = 2'd0;
		for (int m = 0; m < 4; m++) begin
			id[m] = {6'($urandom_range(0, 63)), 2'(m)}; // distinct ids
			setpoint[m] = $urandom;
			rd[m] = '0;
			exp_rep[m] = '0;
			for (int f = 0; f < 4; f++)
				exp_rd[m][f] = '0;
		end
		exp_cmds = 0;
		prev_mode = 2'd0;
		snap = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		if (tx_enable !== 1'b0)
			report_failure("tx_enable is high after reset");
		for (int m = 0; m < 4; m++) begin
			check_error($sformatf("reset error_code %0d", m), mb_pending, error_code[m]);
			check_reading($sformatf("reset position0 %0d", m), 0, position0[m]);
			check_reading($sformatf("reset position1 %0d", m), 0, position1[m]);
			check_reading($sformatf("reset displacement %0d", m), 0, displacement[m]);
			check_reading($sformatf("reset pwm %0d", m), 0, pwm[m]);
		end
		for (int k = 0; k <= POLLS; k++) begin
			wait_request(k + 1);
			if (k > 0)
				judge_poll(k - 1, prev_mode, snap, prev_rd);
			check_id($sformatf("request %0d id", k), id[k % 4], req_id);
			if (!req_crc_ok)
				report_failure($sformatf("request %0d carries a bad crc", k));
			mode <= 2'($urandom_range(0, 3));
			for (int f = 0; f < 4; f++)
				rd[f] <= $urandom;
			if ($urandom_range(0, 1) == 1)
				setpoint[k % 4] <= $urandom;
			@(posedge clk);
			prev_mode = mode;
			snap = setpoint[k % 4];
			for (int f = 0; f < 4; f++)
				prev_rd[f] = rd[f];
		end
		$display("Test OK");
		$finish;
	end

endmodule

// File: testbench/tb_motor_model.sv
`timescale 1ns/1ps
`include "motor_bus_consts.svh"

module tb_motor_model (
	input logic clk,
	input logic line_in, // master tx
	output logic line_out, // master rx
	input logic [7:0] id [4],
	input logic [1:0] mode, // 0 good, 1 bad crc, 2 wrong id, 3 silent
	input logic signed [31:0] rd_pos0,
	input logic signed [31:0] rd_pos1,
	input logic signed [31:0] rd_disp,
	input logic signed [31:0] rd_pwm,
	output int req_count,
	output logic [7:0] req_id,
	output logic req_crc_ok,
	output int cmd_count,
	output logic cmd_crc_ok,
	output logic signed [31:0] cmd_setp [4]
);
	function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] b);
		logic fb;
		for (int i = 7; i >= 0; i--) begin
			fb = crc[15] ^ b[i];
			crc = {crc[14:0], 1'b0};
			if (fb)
				crc = crc ^ 16'h1021;
		end
		return crc;
	endfunction

	task automatic get_byte(output logic [7:0] b);
		@(posedge clk);
		while (line_in)
			@(posedge clk);
		repeat (`MB_BIT_CLKS / 2) @(posedge clk); // mid start bit
		for (int i = 0; i < 8; i++) begin
			repeat (`MB_BIT_CLKS) @(posedge clk);
			b[i] = line_in;
		end
		repeat (`MB_BIT_CLKS) @(posedge clk); // stop bit
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			line_out <= bits[i];
			repeat (`MB_BIT_CLKS) @(posedge clk);
		end
	endtask

	function automatic int motor_of(input logic [7:0] mid);
		for (int m = 0; m < 4; m++)
			if (id[m] == mid)
				return m;
		return -1;
	endfunction

	task automatic send_reply(input logic [7:0] rid);
		logic [7:0] f [`MB_RSP_LEN];
		logic [31:0] words [5];
		logic [15:0] crc;
		int m;
		m = motor_of(rid);
		words[0] = (m >= 0) ? cmd_setp[m] : 32'd0;
		words[1] = rd_pos0;
		words[2] = rd_pos1;
		words[3] = rd_disp;
		words[4] = rd_pwm;
		{f[0], f[1], f[2], f[3]} = `MB_RSP_HEADER;
		f[4] = (mode == 2'd2) ? rid ^ 8'h80 : rid;
		for (int w = 0; w < 5; w++)
			for (int k = 0; k < 4; k++)
				f[5 + 4 * w + k] = words[w][8 * k +: 8]; // little-endian
		crc = 16'hffff;
		for (int i = 4; i < `MB_RSP_LEN - 2; i++)
			crc = crc_update(crc, f[i]);
		if (mode == 2'd1)
			crc = crc ^ 16'h0001;
		f[25] = crc[15:8];
		f[26] = crc[7:0];
		for (int i = 0; i < `MB_RSP_LEN; i++)
			send_byte(f[i]);
	endtask

	initial begin
		logic [31:0] hdr;
		logic [7:0] b [7];
		logic [15:0] crc;
		int m;
		line_out = 1'b1;
		req_count = 0;
		cmd_count = 0;
		req_id = '0;
		req_crc_ok = 1'b0;
		cmd_crc_ok = 1'b0;
		for (int i = 0; i < 4; i++)
			cmd_setp[i] = '0;
		hdr = '0;
		forever begin
			get_byte(b[0]);
			hdr = {hdr[23:0], b[0]};
			if (hdr == `MB_REQ_HEADER) begin
				for (int i = 0; i < 3; i++)
					get_byte(b[i]);
				crc = crc_update(16'hffff, b[0]);
				req_id <= b[0];
				req_crc_ok <= (crc == {b[1], b[2]});
				req_count <= req_count + 1;
				hdr = '0;
				repeat (20) @(posedge clk); // turnaround
				if (mode != 2'd3)
					send_reply(b[0]);
			end else if (hdr == `MB_CMD_HEADER) begin
				for (int i = 0; i < 7; i++)
					get_byte(b[i]);
				crc = 16'hffff;
				for (int i = 0; i < 5; i++)
					crc = crc_update(crc, b[i]);
				m = motor_of(b[0]);
				if (m >= 0)
					cmd_setp[m] <= {b[4], b[3], b[2], b[1]};
				cmd_crc_ok <= (crc == {b[5], b[6]});
				cmd_count <= cmd_count + 1;
				hdr = '0;
			end
		end
	end

endmodule
